//--- hw/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

////////////////////////////////////////
// Core configuration

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Data and address width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

`endif

//--- hw/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    ////////////////////////////////////////
    // Widths

    // Data word, instruction word or address
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

    ////////////////////////////////////////
    // Execute operations

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_slt    = 3'd2,
        alu_xor    = 3'd3,
        alu_or     = 3'd4,
        alu_and    = 3'd5,
        alu_pass_b = 3'd6,  // LUI
        alu_link   = 3'd7   // JAL return address
    } alu_op_t;

    ////////////////////////////////////////
    // Fetch sequencing

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait_resolve
    } fetch_state_t;

endpackage

//--- hw/register_file.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module register_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_core_pkg::reg_addr_t  rs1_addr,
    input  rv_core_pkg::reg_addr_t  rs2_addr,
    output rv_core_pkg::word_t      rs1_data,
    output rv_core_pkg::word_t      rs2_data,
    input  logic                    wr_en,
    input  rv_core_pkg::reg_addr_t  wr_addr,
    input  rv_core_pkg::word_t      wr_data
);

    rv_core_pkg::word_t regs [`RV_NUM_REGS];

    ////////////////////////////////////////
    // Write port

    // Architectural state starts cleared, x0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Read ports

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                resolve_valid,
    input  rv_core_pkg::word_t  next_pc,
    input  logic                imem_ack,
    input  rv_core_pkg::word_t  imem_rdata,
    output logic                imem_cyc,
    output logic                imem_stb,
    output rv_core_pkg::word_t  imem_adr,
    output logic                inst_valid,
    output rv_core_pkg::word_t  inst,
    output rv_core_pkg::word_t  inst_pc
);

    rv_core_pkg::fetch_state_t state;
    rv_core_pkg::word_t        pc;

    ////////////////////////////////////////
    // Fetch sequencer

    // One bus read, then wait for execute to resolve the next PC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rv_core_pkg::fetch_idle;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                rv_core_pkg::fetch_idle: begin
                    state <= rv_core_pkg::fetch_request;
                end
                rv_core_pkg::fetch_request: begin
                    if (imem_ack) begin
                        state <= rv_core_pkg::fetch_wait_resolve;
                    end
                end
                rv_core_pkg::fetch_wait_resolve: begin
                    if (resolve_valid) begin
                        state <= rv_core_pkg::fetch_request;
                        pc    <= next_pc;
                    end
                end
                default: begin
                    state <= rv_core_pkg::fetch_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Wishbone classic read

    assign imem_cyc = (state == rv_core_pkg::fetch_request);
    assign imem_stb = (state == rv_core_pkg::fetch_request);
    assign imem_adr = pc;

    // Data only counts while our own cycle is open
    assign inst_valid = imem_cyc & imem_stb & imem_ack;
    assign inst       = imem_rdata;
    assign inst_pc    = pc;

    ////////////////////////////////////////
    // Bus checks

    stb_needs_cyc: assert property (
        @(posedge clk) disable iff (!arst_n) imem_stb |-> imem_cyc
    ) else $error("fetch: stb without cyc");

    adr_held_until_ack: assert property (
        @(posedge clk) disable iff (!arst_n)
        (imem_stb && !imem_ack) |=> (imem_stb && $stable(imem_adr))
    ) else $error("fetch: request dropped or address changed before ack");

endmodule

//--- hw/decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    inst_valid,
    input  rv_core_pkg::word_t      inst,
    input  rv_core_pkg::word_t      inst_pc,
    output rv_core_pkg::reg_addr_t  rs1_addr,
    output rv_core_pkg::reg_addr_t  rs2_addr,
    input  rv_core_pkg::word_t      rs1_data,
    input  rv_core_pkg::word_t      rs2_data,
    output logic                    issue_valid,
    output rv_core_pkg::alu_op_t    alu_op,
    output rv_core_pkg::word_t      operand_a,
    output rv_core_pkg::word_t      operand_b,
    output rv_core_pkg::word_t      branch_imm,
    output rv_core_pkg::word_t      issue_pc,
    output rv_core_pkg::word_t      issue_inst,
    output rv_core_pkg::reg_addr_t  issue_rd,
    output logic                    issue_rd_we,
    output logic                    is_beq,
    output logic                    is_bne,
    output logic                    is_jal
);

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     imm_i;
    rv_core_pkg::word_t     imm_u;
    rv_core_pkg::word_t     imm_b;
    rv_core_pkg::word_t     imm_j;
    rv_core_pkg::alu_op_t   dec_op;
    logic                   dec_rd_we;
    logic                   dec_use_imm;
    rv_core_pkg::word_t     dec_imm;
    logic                   dec_beq;
    logic                   dec_bne;
    logic                   dec_jal;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rd       = inst[11:7];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    ////////////////////////////////////////
    // Immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    ////////////////////////////////////////
    // Decode
    always_comb begin
        dec_op      = rv_core_pkg::alu_add;
        dec_rd_we   = 1'b0;
        dec_use_imm = 1'b0;
        dec_imm     = imm_i;
        dec_beq     = 1'b0;
        dec_bne     = 1'b0;
        dec_jal     = 1'b0;
        case (opcode)
            opc_lui: begin
                dec_op      = rv_core_pkg::alu_pass_b;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
                dec_rd_we   = 1'b1;
            end
            opc_op_imm, opc_op: begin
                dec_use_imm = (opcode == opc_op_imm);
                dec_rd_we   = 1'b1;
                case (funct3)
                    // SUB only exists in the register form
                    3'b000: dec_op = (opcode == opc_op && inst[30]) ? rv_core_pkg::alu_sub
                                                                    : rv_core_pkg::alu_add;
                    3'b010: dec_op = rv_core_pkg::alu_slt;
                    3'b100: dec_op = rv_core_pkg::alu_xor;
                    3'b110: dec_op = rv_core_pkg::alu_or;
                    3'b111: dec_op = rv_core_pkg::alu_and;
                    default: dec_rd_we = 1'b0;
                endcase
            end
            opc_branch: begin
                dec_beq = (funct3 == 3'b000);
                dec_bne = (funct3 == 3'b001);
            end
            opc_jal: begin
                dec_op    = rv_core_pkg::alu_link;
                dec_jal   = 1'b1;
                dec_rd_we = 1'b1;
            end
            default: begin
                // Anything else retires as a no-op
            end
        endcase
    end

    ////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            alu_op      <= dec_op;
            operand_a   <= rs1_data;
            operand_b   <= dec_use_imm ? dec_imm : rs2_data;
            branch_imm  <= dec_jal ? imm_j : imm_b;
            issue_pc    <= inst_pc;
            issue_inst  <= inst;
            issue_rd    <= rd;
            issue_rd_we <= dec_rd_we && (rd != '0);
            is_beq      <= dec_beq;
            is_bne      <= dec_bne;
            is_jal      <= dec_jal;
        end
    end

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue_valid,
    input  rv_core_pkg::alu_op_t    alu_op,
    input  rv_core_pkg::word_t      operand_a,
    input  rv_core_pkg::word_t      operand_b,
    input  rv_core_pkg::word_t      branch_imm,
    input  rv_core_pkg::word_t      issue_pc,
    input  rv_core_pkg::word_t      issue_inst,
    input  rv_core_pkg::reg_addr_t  issue_rd,
    input  logic                    issue_rd_we,
    input  logic                    is_beq,
    input  logic                    is_bne,
    input  logic                    is_jal,
    output logic                    resolve_valid,
    output rv_core_pkg::word_t      next_pc,
    output logic                    result_valid,
    output rv_core_pkg::word_t      result,
    output rv_core_pkg::word_t      result_pc,
    output rv_core_pkg::word_t      result_inst,
    output rv_core_pkg::reg_addr_t  result_rd,
    output logic                    result_rd_we
);

    rv_core_pkg::word_t alu_result;
    rv_core_pkg::word_t pc_plus_4;
    logic               operands_equal;
    logic               taken;

    assign pc_plus_4 = issue_pc + 32'd4;

    ////////////////////////////////////////
    // ALU
    always_comb begin
        case (alu_op)
            rv_core_pkg::alu_add:    alu_result = operand_a + operand_b;
            rv_core_pkg::alu_sub:    alu_result = operand_a - operand_b;
            rv_core_pkg::alu_slt:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            rv_core_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
            rv_core_pkg::alu_or:     alu_result = operand_a | operand_b;
            rv_core_pkg::alu_and:    alu_result = operand_a & operand_b;
            rv_core_pkg::alu_pass_b: alu_result = operand_b;
            default:                 alu_result = pc_plus_4;
        endcase
    end

    ////////////////////////////////////////
    // Branch resolution
    assign operands_equal = (operand_a == operand_b);
    assign taken = is_jal | (is_beq & operands_equal) | (is_bne & ~operands_equal);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid  <= 1'b0;
            resolve_valid <= 1'b0;
        end else begin
            result_valid  <= issue_valid;
            resolve_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            next_pc      <= taken ? (issue_pc + branch_imm) : pc_plus_4;
            result       <= alu_result;
            result_pc    <= issue_pc;
            result_inst  <= issue_inst;
            result_rd    <= issue_rd;
            result_rd_we <= issue_rd_we;
        end
    end

    // Decode marks at most one control-flow kind per instruction
    one_branch_kind: assert property (
        @(posedge clk) disable iff (!arst_n)
        issue_valid |-> $onehot0({is_beq, is_bne, is_jal})
    ) else $error("execute: more than one branch kind issued");

endmodule

//--- hw/retire_unit.sv
`timescale 1ns/1ps

module retire_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    result_valid,
    input  rv_core_pkg::word_t      result,
    input  rv_core_pkg::word_t      result_pc,
    input  rv_core_pkg::word_t      result_inst,
    input  rv_core_pkg::reg_addr_t  result_rd,
    input  logic                    result_rd_we,
    output logic                    wr_en,
    output rv_core_pkg::reg_addr_t  wr_addr,
    output rv_core_pkg::word_t      wr_data,
    output logic                    retire_valid,
    output rv_core_pkg::word_t      retire_pc,
    output rv_core_pkg::word_t      retire_inst,
    output rv_core_pkg::word_t      retire_data,
    output rv_core_pkg::reg_addr_t  retire_rd,
    output logic                    retire_we,
    output rv_core_pkg::word_t      retired_count
);

    ////////////////////////////////////////
    // Writeback
    assign wr_en   = result_valid & result_rd_we;
    assign wr_addr = result_rd;
    assign wr_data = result;

    ////////////////////////////////////////
    // Retire trace
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            retire_valid <= result_valid;
            if (result_valid) begin
                retired_count <= retired_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            retire_pc   <= result_pc;
            retire_inst <= result_inst;
            retire_data <= result;
            retire_rd   <= result_rd;
            retire_we   <= result_rd_we;
        end
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    imem_cyc,
    output logic                    imem_stb,
    output rv_core_pkg::word_t      imem_adr,
    input  logic                    imem_ack,
    input  rv_core_pkg::word_t      imem_rdata,
    output logic                    retire_valid,
    output rv_core_pkg::word_t      retire_pc,
    output rv_core_pkg::word_t      retire_inst,
    output rv_core_pkg::word_t      retire_data,
    output rv_core_pkg::reg_addr_t  retire_rd,
    output logic                    retire_we,
    output rv_core_pkg::word_t      retired_count
);

    // Fetch to decode
    logic                   inst_valid;
    rv_core_pkg::word_t     inst;
    rv_core_pkg::word_t     inst_pc;
    // Register file
    rv_core_pkg::reg_addr_t rs1_addr, rs2_addr, wr_addr;
    rv_core_pkg::word_t     rs1_data, rs2_data, wr_data;
    logic                   wr_en;
    // Decode to execute
    logic                   issue_valid, issue_rd_we, is_beq, is_bne, is_jal;
    rv_core_pkg::alu_op_t   alu_op;
    rv_core_pkg::word_t     operand_a, operand_b, branch_imm, issue_pc, issue_inst;
    rv_core_pkg::reg_addr_t issue_rd;
    // Execute to fetch and retire
    logic                   resolve_valid, result_valid, result_rd_we;
    rv_core_pkg::word_t     next_pc, result, result_pc, result_inst;
    rv_core_pkg::reg_addr_t result_rd;

    fetch_unit fetch0 (
        .clk, .arst_n, .resolve_valid, .next_pc, .imem_ack, .imem_rdata,
        .imem_cyc, .imem_stb, .imem_adr, .inst_valid, .inst, .inst_pc
    );

    decode_issue decode0 (
        .clk, .arst_n, .inst_valid, .inst, .inst_pc, .rs1_addr, .rs2_addr,
        .rs1_data, .rs2_data, .issue_valid, .alu_op, .operand_a, .operand_b,
        .branch_imm, .issue_pc, .issue_inst, .issue_rd, .issue_rd_we,
        .is_beq, .is_bne, .is_jal
    );

    register_file regfile0 (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en, .wr_addr, .wr_data
    );

    execute_unit execute0 (
        .clk, .arst_n, .issue_valid, .alu_op, .operand_a, .operand_b, .branch_imm,
        .issue_pc, .issue_inst, .issue_rd, .issue_rd_we, .is_beq, .is_bne, .is_jal,
        .resolve_valid, .next_pc, .result_valid, .result, .result_pc, .result_inst,
        .result_rd, .result_rd_we
    );

    retire_unit retire0 (
        .clk, .arst_n, .result_valid, .result, .result_pc, .result_inst, .result_rd,
        .result_rd_we, .wr_en, .wr_addr, .wr_data, .retire_valid, .retire_pc,
        .retire_inst, .retire_data, .retire_rd, .retire_we, .retired_count
    );

endmodule

//--- test/imem_model.sv
`timescale 1ns/1ps

module imem_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic [31:0] adr,
    output logic        ack,
    output logic [31:0] rdata
);

    localparam logic [31:0] seed = 32'd14603;

    logic        ack_q   = 1'b0;
    logic [31:0] rdata_q = 32'd0;
    logic        busy;
    logic [1:0]  waits;
    logic [31:0] wait_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////
    // Program image

    // Word at each address, mostly ALU, with forward branches and jumps
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        int          kind;
        int          op;
        r    = lcg_next(seed ^ addr);
        r    = lcg_next(r ^ (r >> 15));
        s    = lcg_next(r);
        rd   = s[31:27];
        rs1  = s[26:22];
        rs2  = s[21:17];
        kind = int'(r[31:16]) % 100;
        op   = int'(s[16:13]) % 12;
        // JAL forward by 8 or 12
        if (kind >= 85) begin
            return {1'b0, (s[12] ? 10'd6 : 10'd4), 1'b0, 8'd0, rd, 7'b1101111};
        end
        // BEQ or BNE forward by 8
        if (kind >= 70) begin
            f3 = s[12] ? 3'b001 : 3'b000;
            return {7'd0, rs2, rs1, f3, 5'b01000, 7'b1100011};
        end
        case (op)
            1, 6, 7: f3 = 3'b000;
            2, 8:    f3 = 3'b010;
            3, 9:    f3 = 3'b100;
            4, 10:   f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        if (op == 0) begin
            return {r[15:0], s[12:9], rd, 7'b0110111};
        end
        if (op <= 5) begin
            return {r[15:4], rs1, f3, rd, 7'b0010011};
        end
        return {(op == 7) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    ////////////////////////////////////////
    // Wishbone classic slave

    // 0 to 3 wait states per request, ack held for one cycle
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q      <= 1'b0;
            rdata_q    <= 32'd0;
            busy       <= 1'b0;
            waits      <= 2'd0;
            wait_state <= lcg_next(seed);
        end else if (ack_q) begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                busy       <= 1'b1;
                waits      <= wait_state[31:30];
                wait_state <= lcg_next(wait_state);
            end else if (waits == 2'd0) begin
                ack_q   <= 1'b1;
                rdata_q <= inst_at(adr);
            end else begin
                waits <= waits - 2'd1;
            end
        end
    end

    assign ack   = ack_q;
    assign rdata = rdata_q;

endmodule

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;

    localparam int num_inst    = 300;
    localparam int cycle_limit = num_inst * 10;
    localparam int test_bus    = 0;
    localparam int test_alu    = 1;
    localparam int test_flow   = 2;
    localparam int test_jal    = 3;
    localparam int test_timing = 4;
    localparam int num_tests   = 5;

    logic                   clk;
    logic                   arst_n;
    logic                   imem_cyc;
    logic                   imem_stb;
    logic                   imem_ack;
    rv_core_pkg::word_t     imem_adr;
    rv_core_pkg::word_t     imem_rdata;
    logic                   retire_valid;
    logic                   retire_we;
    rv_core_pkg::word_t     retire_pc;
    rv_core_pkg::word_t     retire_inst;
    rv_core_pkg::word_t     retire_data;
    rv_core_pkg::word_t     retired_count;
    rv_core_pkg::reg_addr_t retire_rd;

    // Shadow architectural state
    rv_core_pkg::word_t shadow_regs [32] = '{default: '0};
    rv_core_pkg::word_t exp_pc           = `RV_RESET_PC;

    int         checks [num_tests] = '{default: 0};
    int         errors [num_tests] = '{default: 0};
    int         retire_seen        = 0;
    int         cycles;
    int         total_checks;
    int         total_errors;
    logic       timed_out;
    logic       first_seen         = 1'b0;
    logic       in_flight;
    logic [2:0] ack_hist;

    rv_core dut0 (
        .clk, .arst_n, .imem_cyc, .imem_stb, .imem_adr, .imem_ack, .imem_rdata,
        .retire_valid, .retire_pc, .retire_inst, .retire_data, .retire_rd,
        .retire_we, .retired_count
    );

    imem_model imem0 (
        .clk, .arst_n, .cyc(imem_cyc), .stb(imem_stb), .adr(imem_adr),
        .ack(imem_ack), .rdata(imem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            test_bus:  return "bus protocol";
            test_alu:  return "alu results";
            test_flow: return "control flow";
            test_jal:  return "jal link";
            default:   return "timing and count";
        endcase
    endfunction

    task automatic expect_equal(input int t, input rv_core_pkg::word_t expected,
                                input rv_core_pkg::word_t actual);
        checks[t]++;
        assert (actual == expected) else begin
            errors[t]++;
            $display("MISMATCH %s: expected %h, actual %h at %0t",
                     test_name(t), expected, actual, $time);
        end
    endtask

    task automatic report_failure(input int t, input string what);
        errors[t]++;
        $display("ERROR %s: %s at %0t", test_name(t), what, $time);
    endtask

    ////////////////////////////////////////
    // ISA reference

    task automatic shadow_execute(
        input  rv_core_pkg::word_t     pc,
        output logic                   we,
        output rv_core_pkg::reg_addr_t rd,
        output rv_core_pkg::word_t     data,
        output rv_core_pkg::word_t     next,
        output logic                   jal
    );
        rv_core_pkg::word_t iw;
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t src;
        logic [2:0]         f3;
        iw   = imem0.inst_at(pc);
        rd   = iw[11:7];
        f3   = iw[14:12];
        a    = shadow_regs[iw[19:15]];
        b    = shadow_regs[iw[24:20]];
        we   = 1'b0;
        data = '0;
        next = pc + 32'd4;
        jal  = 1'b0;
        case (iw[6:0])
            7'b0110111: begin
                we   = 1'b1;
                data = {iw[31:12], 12'd0};
            end
            // Opcode bit 5 tells register form from immediate form
            7'b0010011, 7'b0110011: begin
                we  = 1'b1;
                src = iw[5] ? b : {{20{iw[31]}}, iw[31:20]};
                case (f3)
                    3'b000:  data = (iw[5] && iw[30]) ? a - src : a + src;
                    3'b010:  data = ($signed(a) < $signed(src)) ? 32'd1 : 32'd0;
                    3'b100:  data = a ^ src;
                    3'b110:  data = a | src;
                    3'b111:  data = a & src;
                    default: we = 1'b0;
                endcase
            end
            7'b1100011: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    next = pc + {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                we   = 1'b1;
                jal  = 1'b1;
                data = pc + 32'd4;
                next = pc + {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
            end
            default: begin
                // Never generated
            end
        endcase
        we = we && (rd != 5'd0);
    endtask

    ////////////////////////////////////////
    // Bus protocol

    stb_implies_cyc: assert property (
        @(posedge clk) disable iff (!arst_n) imem_stb |-> imem_cyc
    ) else report_failure(test_bus, "stb high without cyc");

    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> !imem_stb
    ) else report_failure(test_bus, "stb high during reset");

    adr_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (imem_stb && !imem_ack) |=> $stable(imem_adr)
    ) else report_failure(test_bus, "address changed before ack");

    adr_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) imem_stb |-> (imem_adr[1:0] == 2'b00)
    ) else report_failure(test_bus, "address not word aligned");

    // First address, ack to retire latency, one instruction in flight
    always @(posedge clk) begin
        if (!arst_n) begin
            ack_hist  <= '0;
            in_flight <= 1'b0;
        end else begin
            ack_hist <= {ack_hist[1:0], imem_cyc & imem_stb & imem_ack};
            if (retire_valid || ack_hist[2]) begin
                expect_equal(test_timing, {31'd0, ack_hist[2]}, {31'd0, retire_valid});
            end
            if (imem_stb) begin
                checks[test_bus]++;
                checks[test_timing]++;
                assert (!(in_flight && !retire_valid))
                else report_failure(test_timing, "new request before previous retire");
            end
            if (imem_stb && !first_seen) begin
                first_seen <= 1'b1;
                expect_equal(test_bus, `RV_RESET_PC, imem_adr);
            end
            if (imem_cyc && imem_stb && imem_ack) begin
                in_flight <= 1'b1;
            end else if (retire_valid) begin
                in_flight <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Retire trace against shadow model

    always @(posedge clk) begin : retire_check
        logic                   exp_we;
        logic                   exp_jal;
        rv_core_pkg::reg_addr_t exp_rd;
        rv_core_pkg::word_t     exp_data;
        rv_core_pkg::word_t     exp_next;
        if (arst_n && retire_valid) begin
            shadow_execute(exp_pc, exp_we, exp_rd, exp_data, exp_next, exp_jal);
            expect_equal(test_flow, exp_pc, retire_pc);
            expect_equal(test_flow, imem0.inst_at(exp_pc), retire_inst);
            expect_equal(test_alu, {31'd0, exp_we}, {31'd0, retire_we});
            if (exp_we) begin
                expect_equal(test_alu, {27'd0, exp_rd}, {27'd0, retire_rd});
                expect_equal(test_alu, exp_data, retire_data);
                shadow_regs[exp_rd] = exp_data;
            end
            if (exp_jal) begin
                expect_equal(test_jal, exp_pc + 32'd4, retire_data);
            end
            expect_equal(test_timing, 32'(retire_seen + 1), retired_count);
            exp_pc = exp_next;
            retire_seen <= retire_seen + 1;
        end
    end

    ////////////////////////////////////////
    // Run control and report

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        while (retire_seen < num_inst && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        timed_out    = (retire_seen < num_inst);
        total_checks = 0;
        total_errors = 0;
        if (timed_out) begin
            $display("Timeout: %0d of %0d instructions retired within %0d cycles",
                     retire_seen, num_inst, cycle_limit);
            total_errors++;
        end
        for (int t = 0; t < num_tests; t++) begin
            $display("%s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
            if (checks[t] == 0) begin
                $display("Test %s never reached a check", test_name(t));
                total_errors++;
            end
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Totals: %0d tests, %0d checks, %0d errors, %0d retired in %0d cycles",
                 num_tests, total_checks, total_errors, retire_seen, cycles);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- rv_core.f
+incdir+hw
hw/rv_core_pkg.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/decode_issue.sv
hw/execute_unit.sv
hw/retire_unit.sv
hw/rv_core.sv
test/imem_model.sv
test/rv_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb -Mdir obj_dir -f rv_core.f
	@out="$$(./obj_dir/Vrv_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
